// File: banked_icache.f
+incdir+rtl
rtl/axi_pkg.sv
rtl/icache_pkg.sv
rtl/icache_bank.sv
rtl/fetch_steer.sv
rtl/refill_mux.sv
rtl/banked_icache.sv
dv/tb_banked_icache.sv

// File: Bender.yml
package:
  name: banked_icache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/axi_pkg.sv
      - rtl/icache_pkg.sv
      - rtl/icache_bank.sv
      - rtl/fetch_steer.sv
      - rtl/refill_mux.sv
      - rtl/banked_icache.sv
  - target: test
    files:
      - dv/tb_banked_icache.sv

// File: dv/tb_banked_icache.sv
// drives banked_icache against an AXI read memory with random 0-3 cycle delays
// memory word is its address xor a key that changes at every fence
// stops at the first mismatch or timeout
module tb_banked_icache
	import axi_pkg::*, icache_pkg::*;
();
	localparam int TIMEOUT = 100;

	typedef struct packed {
		logic [31:0] addr;
		logic        is_fence;
		logic        from_idle; // drop select for a cycle before this fetch
		logic [31:0] exp_data;
		logic [7:0]  exp_ars;   // AR transfers seen so far
	} entry_t;

	logic       clock;
	logic       reset;
	logic       fetch_sel;
	fetch_req_t fetch_req;
	logic       fence;
	logic       fetch_ready;
	fetch_rsp_t fetch_rsp;
	logic       m_ar_valid;
	axi_ar_t    m_ar;
	logic       m_ar_ready;
	logic       m_r_valid;
	axi_r_t     m_r;
	logic       m_r_ready;

	entry_t  table_q [$];
	axi_ar_t ar_log [$];
	int      generation;
	int      build_gen;
	integer  seed = 3;

	banked_icache uut (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] mem_key(input int gen);
		return 32'h5a3c_0000 ^ (gen * 32'h0013_7100);
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("ERR %0t: %s got %h expected %h", $time, what, actual, expected);
			$display("SIMULATION FAILED");
			$fatal(1, "first mismatch");
		end
	endtask

	task automatic check_ar(input axi_ar_t ar, input logic [31:0] addr);
		check_value(ar.addr, addr & ~32'hf, "AR line address");
		check_value(32'(ar.len), 32'd3, "AR len");        // 4 beats per 16-byte line
		check_value(32'(ar.size), 32'b010, "AR size");    // 4-byte beats
		check_value(32'(ar.burst), 32'b01, "AR burst");   // INCR
	endtask

	task automatic add_fetch(input logic [31:0] addr, input logic from_idle, input int ars);
		entry_t e;
		e.addr      = addr;
		e.is_fence  = 1'b0;
		e.from_idle = from_idle;
		e.exp_data  = addr ^ mem_key(build_gen);
		e.exp_ars   = 8'(ars);
		table_q.push_back(e);
	endtask

	task automatic add_fence(input int ars);
		entry_t e;
		e          = '0;
		e.is_fence = 1'b1;
		e.exp_ars  = 8'(ars);
		table_q.push_back(e);
		build_gen++;
	endtask

	task automatic build_table();
		build_gen = 0;
		add_fetch(32'h0000_1000, 1, 1); // cold miss in bank 0 index 0
		add_fetch(32'h0000_100c, 0, 1);
		add_fetch(32'h0000_1004, 1, 1); // hit from idle
		add_fetch(32'h0000_1008, 0, 1);
		add_fetch(32'h0000_1010, 0, 2); // same line in bank 1
		add_fetch(32'h0000_101c, 0, 2);
		add_fetch(32'h0000_1000, 0, 2); // both banks resident
		add_fetch(32'h0000_1014, 0, 2);
		add_fetch(32'h0000_1104, 0, 3); // new tag evicts 0x1000
		add_fetch(32'h0000_1018, 1, 3);
		add_fetch(32'h0000_1000, 0, 4);
		add_fetch(32'h0000_1048, 0, 5);
		add_fetch(32'h0000_104c, 1, 5);
		add_fence(5);
		add_fetch(32'h0000_1000, 0, 6); // everything misses after the fence
		add_fetch(32'h0000_1010, 0, 7);
		add_fetch(32'h0000_1048, 0, 8);
		add_fetch(32'h0000_1104, 0, 9);
		add_fetch(32'h0000_1108, 1, 9);
		add_fetch(32'h0000_2ff0, 0, 10); // bank 1 index 7
		add_fetch(32'h0000_2ffc, 0, 10);
	endtask

	// AR monitor
	always @(posedge clock) begin
		if (!reset && m_ar_valid && m_ar_ready) begin
			ar_log.push_back(m_ar);
		end
	end

	initial begin : memory
		logic [31:0] base;
		logic [7:0]  len;
		int          delay;
		m_ar_ready = 1'b0;
		m_r_valid  = 1'b0;
		m_r        = '0;
		forever begin
			@(negedge clock);
			if (!reset && m_ar_valid) begin
				base  = m_ar.addr;
				len   = m_ar.len;
				delay = $random(seed) & 3;
				repeat (delay) @(negedge clock);
				m_ar_ready = 1'b1; // taken at the next rising edge
				@(negedge clock);
				m_ar_ready = 1'b0;
				for (int beat = 0; beat <= len; beat++) begin
					delay = $random(seed) & 3;
					repeat (delay) @(negedge clock);
					m_r_valid = 1'b1;
					m_r.data  = (base + 4 * beat) ^ mem_key(generation);
					m_r.last  = (beat == len);
					check_value(m_r_ready, 1, "r_ready during beat");
					@(negedge clock);
					m_r_valid = 1'b0;
				end
			end
		end
	end

	initial begin : stimulus
		entry_t e;
		int     lat;
		int     prev_ars;
		reset      = 1'b1;
		fetch_sel  = 1'b0;
		fetch_req  = '0;
		fence      = 1'b0;
		generation = 0;
		prev_ars   = 0;
		build_table();
		repeat (16) @(negedge clock);
		reset = 1'b0;
		foreach (table_q[i]) begin
			e = table_q[i];
			if (e.is_fence) begin
				fetch_sel = 1'b0;
				@(negedge clock);
				fence = 1'b1;
				generation++; // code in memory changes with the fence
				@(negedge clock);
				fence = 1'b0;
				@(negedge clock);
			end else begin
				if (e.from_idle && fetch_sel) begin
					fetch_sel = 1'b0;
					@(negedge clock);
				end
				fetch_sel      = 1'b1;
				fetch_req.addr = e.addr;
				lat            = 0;
				do begin
					@(negedge clock);
					lat++;
					if (lat > TIMEOUT) begin
						$display("timeout: no fetch_ready for address %h after %0d cycles",
							e.addr, lat);
						$display("SIMULATION FAILED");
						$fatal(1, "fetch timed out");
					end
				end while (!fetch_ready);
				check_value(fetch_rsp.rdata, e.exp_data, "fetch data");
				if (e.from_idle && e.exp_ars == prev_ars) begin
					check_value(lat, 2, "hit latency from idle");
				end
				if (e.exp_ars != prev_ars) begin
					check_ar(ar_log[ar_log.size() - 1], e.addr);
				end
			end
			check_value(ar_log.size(), e.exp_ars, "AR count");
			prev_ars = e.exp_ars;
		end
		fetch_sel = 1'b0;
		repeat (4) @(negedge clock);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: rtl/banked_icache.sv
// read-only banked instruction cache with one fetch outstanding
// fence is legal only between fetches
`include "icache_defines.svh"

module banked_icache
	import axi_pkg::*, icache_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  logic       fetch_sel,
	input  fetch_req_t fetch_req,
	input  logic       fence,
	output logic       fetch_ready,
	output fetch_rsp_t fetch_rsp,
	output logic       m_ar_valid,
	output axi_ar_t    m_ar,
	input  logic       m_ar_ready,
	input  logic       m_r_valid,
	input  axi_r_t     m_r,
	output logic       m_r_ready
);
	logic [`ICACHE_BANKS-1:0] bank_sel;
	logic [`ICACHE_BANKS-1:0] bank_ready;
	logic                     bank_fence;
	fetch_rsp_t               bank_rsp [`ICACHE_BANKS];
	logic [`ICACHE_BANKS-1:0] ar_valid;
	axi_ar_t                  ar [`ICACHE_BANKS];
	logic [`ICACHE_BANKS-1:0] ar_ready;
	logic [`ICACHE_BANKS-1:0] r_valid;
	axi_r_t                   r;
	logic [`ICACHE_BANKS-1:0] r_ready;

	fetch_steer u_steer (
		.clock       (clock),
		.reset       (reset),
		.fetch_sel   (fetch_sel),
		.fetch_req   (fetch_req),
		.fence       (fence),
		.fetch_ready (fetch_ready),
		.fetch_rsp   (fetch_rsp),
		.bank_sel    (bank_sel),
		.bank_fence  (bank_fence),
		.bank_ready  (bank_ready),
		.bank_rsp    (bank_rsp)
	);

	for (genvar g = 0; g < `ICACHE_BANKS; g++) begin : g_bank
		icache_bank u_bank (
			.clock    (clock),
			.reset    (reset),
			.sel      (bank_sel[g]),
			.req      (fetch_req),
			.fence    (bank_fence),
			.ready    (bank_ready[g]),
			.rsp      (bank_rsp[g]),
			.ar_valid (ar_valid[g]),
			.ar       (ar[g]),
			.ar_ready (ar_ready[g]),
			.r_valid  (r_valid[g]),
			.r        (r),
			.r_ready  (r_ready[g])
		);
	end

	refill_mux u_refill (
		.clock         (clock),
		.reset         (reset),
		.bank_ar_valid (ar_valid),
		.bank_ar       (ar),
		.bank_ar_ready (ar_ready),
		.bank_r_valid  (r_valid),
		.bank_r        (r),
		.bank_r_ready  (r_ready),
		.m_ar_valid    (m_ar_valid),
		.m_ar          (m_ar),
		.m_ar_ready    (m_ar_ready),
		.m_r_valid     (m_r_valid),
		.m_r           (m_r),
		.m_r_ready     (m_r_ready)
	);

endmodule

// File: rtl/refill_mux.sv
// merges the banks' refill bursts onto one AXI read port
// fixed priority with the lowest bank first
// one burst in flight at a time
`include "icache_defines.svh"

module refill_mux
	import axi_pkg::*;
(
	input  logic                     clock,
	input  logic                     reset,
	input  logic [`ICACHE_BANKS-1:0] bank_ar_valid,
	input  axi_ar_t                  bank_ar [`ICACHE_BANKS],
	output logic [`ICACHE_BANKS-1:0] bank_ar_ready,
	output logic [`ICACHE_BANKS-1:0] bank_r_valid,
	output axi_r_t                   bank_r,
	input  logic [`ICACHE_BANKS-1:0] bank_r_ready,
	output logic                     m_ar_valid,
	output axi_ar_t                  m_ar,
	input  logic                     m_ar_ready,
	input  logic                     m_r_valid,
	input  axi_r_t                   m_r,
	output logic                     m_r_ready
);
	logic                      locked;
	logic [`ICACHE_BANK_W-1:0] grant;
	logic [`ICACHE_BANK_W-1:0] pick;

	always_comb begin
		pick = '0;
		for (int i = `ICACHE_BANKS - 1; i >= 0; i--) begin
			if (bank_ar_valid[i]) begin
				pick = i[`ICACHE_BANK_W-1:0]; // last hit is the lowest bank
			end
		end
	end

	assign m_ar_valid = !locked && (|bank_ar_valid);
	assign m_ar       = bank_ar[pick];

	always_comb begin
		bank_ar_ready       = '0;
		bank_ar_ready[pick] = m_ar_ready && !locked;
	end

	always_comb begin
		bank_r_valid        = '0;
		bank_r_valid[grant] = m_r_valid && locked;
	end

	assign bank_r    = m_r; // data and last are shared while valid is steered
	assign m_r_ready = locked && bank_r_ready[grant];

	always_ff @(posedge clock) begin
		if (reset) begin
			locked <= 1'b0;
			grant  <= '0;
		end else if (!locked && m_ar_valid && m_ar_ready) begin
			locked <= 1'b1;
			grant  <= pick;
		end else if (locked && m_r_valid && m_r_ready && m_r.last) begin
			locked <= 1'b0; // burst done
		end
	end

	// memory answers only bursts it has accepted
	assert property (@(posedge clock) disable iff (reset)
		m_r_valid |-> locked);

endmodule

// File: rtl/fetch_steer.sv
// routes a fetch to the bank named by its bank bit
// fence goes to every bank and must not overlap a fetch
`include "icache_defines.svh"

module fetch_steer
	import icache_pkg::*;
(
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     fetch_sel,
	input  fetch_req_t               fetch_req,
	input  logic                     fence,
	output logic                     fetch_ready,
	output fetch_rsp_t               fetch_rsp,
	output logic [`ICACHE_BANKS-1:0] bank_sel,
	output logic                     bank_fence,
	input  logic [`ICACHE_BANKS-1:0] bank_ready,
	input  fetch_rsp_t               bank_rsp [`ICACHE_BANKS]
);
	addr_fields_t fields;

	assign fields = addr_fields_t'(fetch_req.addr);

	always_comb begin
		bank_sel              = '0;
		bank_sel[fields.bank] = fetch_sel; // one-hot select
	end

	assign fetch_ready = bank_ready[fields.bank];
	assign fetch_rsp   = bank_rsp[fields.bank];
	assign bank_fence  = fence;

	assert property (@(posedge clock) disable iff (reset)
		!(fence && fetch_sel));

	// only the bank that owns the fetch may answer
	assert property (@(posedge clock) disable iff (reset)
		$onehot0(bank_ready));

endmodule

// File: rtl/icache_bank.sv
// one direct-mapped bank that serves one fetch at a time
// refill is a single line-aligned INCR burst of ICACHE_BEATS words
// the core must hold req stable until ready
`include "icache_defines.svh"

module icache_bank
	import axi_pkg::*, icache_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  logic       sel,
	input  fetch_req_t req,
	input  logic       fence,
	output logic       ready,
	output fetch_rsp_t rsp,
	output logic       ar_valid,
	output axi_ar_t    ar,
	input  logic       ar_ready,
	input  logic       r_valid,
	input  axi_r_t     r,
	output logic       r_ready
);
	localparam int LINES = 1 << `ICACHE_INDEX_W;

	typedef enum logic [2:0] {
		ST_IDLE   = 3'b000,
		ST_CHECK  = 3'b001,
		ST_AR     = 3'b010,
		ST_LOAD   = 3'b011,
		ST_PASS   = 3'b100,
		ST_UPDATE = 3'b101,
		ST_FENCE  = 3'b111
	} state_t;

	state_t           state;
	state_t           next_state;
	addr_fields_t     fields;
	tag_t             tags  [LINES];
	line_t            lines [LINES];
	logic [LINES-1:0] valid;
	logic             hit;

	assign fields = addr_fields_t'(req.addr);
	assign hit    = valid[fields.index] && (tags[fields.index] == fields.tag);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE: begin
				if (sel) begin
					next_state = ST_CHECK;
				end else if (fence) begin
					next_state = ST_FENCE;
				end
			end
			ST_CHECK: begin
				if (!sel) begin
					// core moved on to another bank or went quiet
					next_state = fence ? ST_FENCE : ST_IDLE;
				end else if (hit) begin
					next_state = ST_PASS;
				end else begin
					next_state = ST_AR;
				end
			end
			ST_AR: begin
				if (ar_ready) begin
					next_state = ST_LOAD;
				end
			end
			ST_LOAD: begin
				if (r_valid && r.last) begin
					next_state = ST_UPDATE;
				end
			end
			ST_UPDATE: next_state = ST_PASS;
			ST_PASS: begin
				if (sel) begin
					next_state = ST_CHECK; // back-to-back fetch
				end else if (fence) begin
					next_state = ST_FENCE;
				end else begin
					next_state = ST_IDLE;
				end
			end
			ST_FENCE: next_state = ST_IDLE;
			default:  next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else if (state == ST_FENCE) begin
			valid <= '0;
		end else if (state == ST_CHECK && sel && !hit) begin
			valid[fields.index] <= 1'b0; // old line gets overwritten by the refill
		end else if (state == ST_UPDATE) begin
			valid[fields.index] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (state == ST_UPDATE) begin
			tags[fields.index] <= fields.tag;
		end
		if (state == ST_LOAD && r_valid) begin
			// beats shift in from the top so word 0 ends at the bottom
			lines[fields.index] <= {r.data, lines[fields.index][`ICACHE_BEATS-1:1]};
		end
	end

	assign ready     = (state == ST_PASS);
	assign rsp.rdata = lines[fields.index][fields.word];

	assign ar_valid = (state == ST_AR);
	assign ar.addr  = {fields.tag, fields.index, fields.bank, {`ICACHE_OFFSET_W{1'b0}}};
	assign ar.len   = 8'(`ICACHE_BEATS - 1);
	assign ar.size  = AXI_SIZE_4B;
	assign ar.burst = AXI_BURST_INCR;
	assign r_ready  = (state == ST_LOAD);

	// request held by the core, so the AR payload cannot move while waiting
	assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> $stable(ar));

	// the refill mux only offers beats to a bank that is loading
	assert property (@(posedge clock) disable iff (reset)
		r_valid |-> r_ready);

endmodule

// File: rtl/icache_pkg.sv
// fetch port and cache-side types
// addr_fields_t must add up to the full address width
`include "icache_defines.svh"

package icache_pkg;

	typedef struct packed {
		logic [`ICACHE_ADDR_W-1:0] addr;
	} fetch_req_t;

	typedef struct packed {
		logic [`ICACHE_DATA_W-1:0] rdata;
	} fetch_rsp_t;

	typedef logic [`ICACHE_TAG_W-1:0]      tag_t;
	typedef logic [`ICACHE_INDEX_W-1:0]    index_t;
	typedef logic [`ICACHE_BANK_W-1:0]     bank_t;
	typedef logic [`ICACHE_WORD_SEL_W-1:0] word_t;

	// fetch address split, msb first
	typedef struct packed {
		tag_t                          tag;
		index_t                        index;
		bank_t                         bank;
		word_t                         word;
		logic [`ICACHE_BYTE_OFF_W-1:0] byte_off; // ignored since fetches are word aligned
	} addr_fields_t;

	// word 0 sits in the low bits
	typedef logic [`ICACHE_BEATS-1:0][`ICACHE_DATA_W-1:0] line_t;

endpackage

// File: rtl/axi_pkg.sv
// AXI4 read channels only, no write side and no rresp
// valid/ready travel beside the structs
`include "icache_defines.svh"

package axi_pkg;

	// read address channel payload
	typedef struct packed {
		logic [`ICACHE_ADDR_W-1:0] addr;
		logic [7:0]                len;   // beats minus one
		logic [2:0]                size;
		logic [1:0]                burst;
	} axi_ar_t;

	// read data channel payload
	typedef struct packed {
		logic [`ICACHE_DATA_W-1:0] data;
		logic                      last;
	} axi_r_t;

	// burst type code for incrementing bursts
	localparam logic [1:0] AXI_BURST_INCR = 2'b01;

	// beat size code for 4 bytes
	localparam logic [2:0] AXI_SIZE_4B = 3'b010;

endpackage

// File: rtl/icache_defines.svh
// cache geometry shared by packages and RTL
// the word is fixed at 32 bits to match the 4-byte AXI beat
// a line must hold at least two words
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// fetch address width
`define ICACHE_ADDR_W 32

// instruction word width
`define ICACHE_DATA_W 32

// byte offset inside a 16-byte line
`define ICACHE_OFFSET_W 4

// byte inside one word
`define ICACHE_BYTE_OFF_W 2

// word select inside a line
`define ICACHE_WORD_SEL_W (`ICACHE_OFFSET_W - `ICACHE_BYTE_OFF_W)

// words per line, also beats per refill
`define ICACHE_BEATS (1 << `ICACHE_WORD_SEL_W)

// address bits that pick a bank
`define ICACHE_BANK_W 1
`define ICACHE_BANKS (1 << `ICACHE_BANK_W)

// lines per bank are 1 << ICACHE_INDEX_W
`define ICACHE_INDEX_W 3

`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_OFFSET_W - `ICACHE_BANK_W - `ICACHE_INDEX_W)

`endif
